/* hw/alu.sv */
`timescale 1ns/1ps

module alu import isa_pkg::*; (
  input  alu_op_t         alu_op,
  input  logic [XLEN-1:0] alu_src1,
  input  logic [XLEN-1:0] alu_src2,
  output logic [XLEN-1:0] alu_result
);

  logic [XLEN-1:0]    add_res;
  logic [XLEN-1:0]    sub_res;
  logic [XLEN-1:0]    slt_res;
  logic [XLEN-1:0]    sltu_res;
  logic [XLEN-1:0]    sll_res;
  logic [XLEN-1:0]    srl_res;
  logic [XLEN-1:0]    sra_res;
  logic [SHAMT_W-1:0] shamt;

  assign shamt = alu_src2[SHAMT_W-1:0];

  assign add_res  = alu_src1 + alu_src2;
  assign sub_res  = alu_src1 - alu_src2;
  assign slt_res  = {{(XLEN-1){1'b0}}, $signed(alu_src1) < $signed(alu_src2)};
  assign sltu_res = {{(XLEN-1){1'b0}}, alu_src1 < alu_src2};

  assign sll_res = alu_src1 << shamt;
  assign srl_res = alu_src1 >> shamt;
  assign sra_res = $signed(alu_src1) >>> shamt;

  // and-or select, exactly one op bit is set
  assign alu_result = ({XLEN{alu_op[ALU_ADD]}}  & add_res)
                    | ({XLEN{alu_op[ALU_SUB]}}  & sub_res)
                    | ({XLEN{alu_op[ALU_SLT]}}  & slt_res)
                    | ({XLEN{alu_op[ALU_SLTU]}} & sltu_res)
                    | ({XLEN{alu_op[ALU_AND]}}  & (alu_src1 & alu_src2))
                    | ({XLEN{alu_op[ALU_NOR]}}  & ~(alu_src1 | alu_src2))
                    | ({XLEN{alu_op[ALU_OR]}}   & (alu_src1 | alu_src2))
                    | ({XLEN{alu_op[ALU_XOR]}}  & (alu_src1 ^ alu_src2))
                    | ({XLEN{alu_op[ALU_SLL]}}  & sll_res)
                    | ({XLEN{alu_op[ALU_SRL]}}  & srl_res)
                    | ({XLEN{alu_op[ALU_SRA]}}  & sra_res)
                    // lui gets its upper immediate already shifted by decode
                    | ({XLEN{alu_op[ALU_LUI]}}  & alu_src2);

endmodule

/* hw/data_ram.sv */
`timescale 1ns/1ps

module data_ram import isa_pkg::*, pipe_types_pkg::*; (
  input  logic               clk,
  input  logic               en,
  input  logic               we,
  input  logic [DMEM_AW-1:0] addr,
  input  logic [XLEN-1:0]    wdata,
  output logic [XLEN-1:0]    rdata
);

  logic [XLEN-1:0] mem [DMEM_WORDS];

  always_ff @(posedge clk) begin
    if (en && we) begin
      mem[addr] <= wdata;
    end
  end

  // read port keeps its last value between reads
  always_ff @(posedge clk) begin
    if (en && !we) begin
      rdata <= mem[addr];
    end
  end

endmodule

/* hw/exe_pipe_top.sv */
`timescale 1ns/1ps

module exe_pipe_top import isa_pkg::*, pipe_types_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      op_valid,
  output logic      op_ready,
  input  issue_op_t op,
  output logic      retire_valid,
  input  logic      retire_ready,
  output retire_t   retire
);

  logic               es_allowin;
  logic               ms_allowin;
  logic               ws_allowin;
  logic               ds2es_valid;
  logic               es2ms_valid;
  logic               ms2ws_valid;
  exe_bus_t           ds2es_bus;
  mem_bus_t           es2ms_bus;
  wb_bus_t            ms2ws_bus;
  fwd_t               exe_fwd;
  fwd_t               mem_fwd;
  fwd_t               wb_fwd;
  rf_write_t          rf_write;
  logic               data_en;
  logic               data_we;
  logic [DMEM_AW-1:0] data_addr;
  logic [XLEN-1:0]    data_wdata;
  logic [XLEN-1:0]    data_rdata;

  issue_stage u_issue (
    .clk, .reset, .op_valid, .op_ready, .op,
    .es_allowin, .ds2es_valid, .ds2es_bus,
    .exe_fwd, .mem_fwd, .wb_fwd, .rf_write
  );

  exe_stage u_exe (
    .clk, .reset, .ds2es_valid, .ds2es_bus, .es_allowin,
    .ms_allowin, .es2ms_valid, .es2ms_bus, .exe_fwd,
    .data_en, .data_we, .data_addr, .data_wdata
  );

  data_ram u_dmem (
    .clk, .en(data_en), .we(data_we), .addr(data_addr),
    .wdata(data_wdata), .rdata(data_rdata)
  );

  mem_stage u_mem (
    .clk, .reset, .es2ms_valid, .es2ms_bus, .ms_allowin,
    .ws_allowin, .ms2ws_valid, .ms2ws_bus, .mem_fwd, .data_rdata
  );

  wb_stage u_wb (
    .clk, .reset, .ms2ws_valid, .ms2ws_bus, .ws_allowin,
    .retire_valid, .retire_ready, .retire, .wb_fwd, .rf_write
  );

endmodule

/* hw/exe_stage.sv */
`timescale 1ns/1ps

module exe_stage import isa_pkg::*, pipe_types_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               ds2es_valid,
  input  exe_bus_t           ds2es_bus,
  output logic               es_allowin,
  input  logic               ms_allowin,
  output logic               es2ms_valid,
  output mem_bus_t           es2ms_bus,
  output fwd_t               exe_fwd,
  output logic               data_en,
  output logic               data_we,
  output logic [DMEM_AW-1:0] data_addr,
  output logic [XLEN-1:0]    data_wdata
);

  logic            es_valid;
  exe_bus_t        es_bus;
  logic [XLEN-1:0] alu_result;
  logic            handoff;

  // the alu never takes more than one cycle
  assign es_allowin  = !es_valid || ms_allowin;
  assign es2ms_valid = es_valid;
  assign handoff     = es_valid && ms_allowin;

  always_ff @(posedge clk) begin
    if (reset) begin
      es_valid <= 1'b0;
    end else if (es_allowin) begin
      es_valid <= ds2es_valid;
    end
    if (ds2es_valid && es_allowin) begin
      es_bus <= ds2es_bus;
    end
  end

  alu u_alu (
    .alu_op     (es_bus.alu_op),
    .alu_src1   (es_bus.alu_src1),
    .alu_src2   (es_bus.alu_src2),
    .alu_result (alu_result)
  );

  // memory access only in the cycle the op moves on, so a stall never repeats it
  assign data_en    = handoff && (es_bus.res_from_mem || es_bus.mem_we);
  assign data_we    = handoff && es_bus.mem_we;
  assign data_addr  = alu_result[DMEM_AW+1:2];
  assign data_wdata = es_bus.st_data;

  assign es2ms_bus.pc           = es_bus.pc;
  assign es2ms_bus.alu_result   = alu_result;
  assign es2ms_bus.res_from_mem = es_bus.res_from_mem;
  assign es2ms_bus.gr_we        = es_bus.gr_we;
  assign es2ms_bus.dest         = es_bus.dest;

  assign exe_fwd.valid   = es_valid;
  assign exe_fwd.gr_we   = es_bus.gr_we;
  assign exe_fwd.is_load = es_bus.res_from_mem;
  assign exe_fwd.dest    = es_bus.dest;
  assign exe_fwd.value   = alu_result;

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;
  localparam int REG_AW   = $clog2(NUM_REGS);
  localparam int SHAMT_W  = 5;

  // one-hot alu operation code
  localparam int ALU_OP_W = 12;
  typedef logic [ALU_OP_W-1:0] alu_op_t;

  // bit positions inside alu_op_t
  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND  = 4;
  localparam int ALU_NOR  = 5;
  localparam int ALU_OR   = 6;
  localparam int ALU_XOR  = 7;
  localparam int ALU_SLL  = 8;
  localparam int ALU_SRL  = 9;
  localparam int ALU_SRA  = 10;
  localparam int ALU_LUI  = 11;

endpackage

/* hw/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage import isa_pkg::*, pipe_types_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      op_valid,
  output logic      op_ready,
  input  issue_op_t op,
  input  logic      es_allowin,
  output logic      ds2es_valid,
  output exe_bus_t  ds2es_bus,
  input  fwd_t      exe_fwd,
  input  fwd_t      mem_fwd,
  input  fwd_t      wb_fwd,
  input  rf_write_t rf_write
);

  logic            ds_valid;
  issue_op_t       ds_op;
  logic [XLEN-1:0] rf [NUM_REGS];
  logic            ds_ready_go;
  logic            need_src2;
  logic            load_use;
  logic [XLEN-1:0] src1_val;
  logic [XLEN-1:0] src2_val;

  function automatic logic fwd_hit(input fwd_t f, input logic [REG_AW-1:0] src);
    return f.valid && f.gr_we && (f.dest == src) && (src != '0);
  endfunction

  // execute first, then memory, then writeback, then the register file
  function automatic logic [XLEN-1:0] pick_operand(
    input logic [REG_AW-1:0] src,
    input fwd_t              ef,
    input fwd_t              mf,
    input fwd_t              wf,
    input logic [XLEN-1:0]   rf_val
  );
    logic [XLEN-1:0] val;
    if (src == '0) val = '0;
    else if (fwd_hit(ef, src)) val = ef.value;
    else if (fwd_hit(mf, src)) val = mf.value;
    else if (fwd_hit(wf, src)) val = wf.value;
    else val = rf_val;
    return val;
  endfunction

  // store data is read from src2 even with an immediate operand
  assign need_src2 = !ds_op.use_imm || ds_op.mem_we;

  assign load_use = exe_fwd.is_load &&
                    (fwd_hit(exe_fwd, ds_op.src1) ||
                     (need_src2 && fwd_hit(exe_fwd, ds_op.src2)));

  assign ds_ready_go = !load_use;
  assign op_ready    = !ds_valid || (ds_ready_go && es_allowin);
  assign ds2es_valid = ds_valid && ds_ready_go;

  assign src1_val = pick_operand(ds_op.src1, exe_fwd, mem_fwd, wb_fwd, rf[ds_op.src1]);
  assign src2_val = pick_operand(ds_op.src2, exe_fwd, mem_fwd, wb_fwd, rf[ds_op.src2]);

  always_comb begin
    ds2es_bus.pc           = ds_op.pc;
    ds2es_bus.alu_op       = ds_op.alu_op;
    ds2es_bus.alu_src1     = src1_val;
    ds2es_bus.alu_src2     = ds_op.use_imm ? ds_op.imm : src2_val;
    ds2es_bus.st_data      = src2_val;
    ds2es_bus.res_from_mem = ds_op.res_from_mem;
    ds2es_bus.mem_we       = ds_op.mem_we;
    ds2es_bus.gr_we        = ds_op.gr_we;
    ds2es_bus.dest         = ds_op.dest;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ds_valid <= 1'b0;
    end else if (op_ready) begin
      ds_valid <= op_valid;
    end
    if (op_valid && op_ready) begin
      ds_op <= op;
    end
  end

  // architectural registers start from zero, r0 is never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (rf_write.we && rf_write.addr != '0) begin
      rf[rf_write.addr] <= rf_write.data;
    end
  end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import isa_pkg::*, pipe_types_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            es2ms_valid,
  input  mem_bus_t        es2ms_bus,
  output logic            ms_allowin,
  input  logic            ws_allowin,
  output logic            ms2ws_valid,
  output wb_bus_t         ms2ws_bus,
  output fwd_t            mem_fwd,
  input  logic [XLEN-1:0] data_rdata
);

  logic            ms_valid;
  logic            ms_first;
  mem_bus_t        ms_bus;
  logic [XLEN-1:0] ld_data_q;
  logic [XLEN-1:0] ld_data;
  logic [XLEN-1:0] result;

  assign ms_allowin  = !ms_valid || ws_allowin;
  assign ms2ws_valid = ms_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      ms_valid <= 1'b0;
      ms_first <= 1'b0;
    end else begin
      if (ms_allowin) begin
        ms_valid <= es2ms_valid;
      end
      // first cycle of a newly entered op
      ms_first <= es2ms_valid && ms_allowin;
    end
    if (es2ms_valid && ms_allowin) begin
      ms_bus <= es2ms_bus;
    end
    if (ms_first) begin
      ld_data_q <= data_rdata;
    end
  end

  // ram output is only valid in the first cycle, later use the copy
  assign ld_data = ms_first ? data_rdata : ld_data_q;
  assign result  = ms_bus.res_from_mem ? ld_data : ms_bus.alu_result;

  assign ms2ws_bus.pc     = ms_bus.pc;
  assign ms2ws_bus.result = result;
  assign ms2ws_bus.gr_we  = ms_bus.gr_we;
  assign ms2ws_bus.dest   = ms_bus.dest;

  assign mem_fwd.valid   = ms_valid;
  assign mem_fwd.gr_we   = ms_bus.gr_we;
  assign mem_fwd.is_load = 1'b0;
  assign mem_fwd.dest    = ms_bus.dest;
  assign mem_fwd.value   = result;

endmodule

/* hw/pipe_types_pkg.sv */
package pipe_types_pkg;
  import isa_pkg::*;

  // data memory geometry, in 32-bit words
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = 8;

  // decoded op as it arrives at the pipeline input
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    alu_op_t           alu_op;
    logic [REG_AW-1:0] src1;
    logic [REG_AW-1:0] src2;
    logic [XLEN-1:0]   imm;
    logic              use_imm;
    logic              res_from_mem;
    logic              mem_we;
    logic              gr_we;
    logic [REG_AW-1:0] dest;
  } issue_op_t;

  // issue to execute
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    alu_op_t           alu_op;
    logic [XLEN-1:0]   alu_src1;
    logic [XLEN-1:0]   alu_src2;
    logic [XLEN-1:0]   st_data;
    logic              res_from_mem;
    logic              mem_we;
    logic              gr_we;
    logic [REG_AW-1:0] dest;
  } exe_bus_t;

  // execute to memory
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   alu_result;
    logic              res_from_mem;
    logic              gr_we;
    logic [REG_AW-1:0] dest;
  } mem_bus_t;

  // memory to writeback
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   result;
    logic              gr_we;
    logic [REG_AW-1:0] dest;
  } wb_bus_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic              gr_we;
    logic [REG_AW-1:0] dest;
    logic [XLEN-1:0]   result;
  } retire_t;

  // is_load marks a value that is not available yet
  typedef struct packed {
    logic              valid;
    logic              gr_we;
    logic              is_load;
    logic [REG_AW-1:0] dest;
    logic [XLEN-1:0]   value;
  } fwd_t;

  typedef struct packed {
    logic              we;
    logic [REG_AW-1:0] addr;
    logic [XLEN-1:0]   data;
  } rf_write_t;

endpackage

/* hw/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage import pipe_types_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      ms2ws_valid,
  input  wb_bus_t   ms2ws_bus,
  output logic      ws_allowin,
  output logic      retire_valid,
  input  logic      retire_ready,
  output retire_t   retire,
  output fwd_t      wb_fwd,
  output rf_write_t rf_write
);

  logic    ws_valid;
  wb_bus_t ws_bus;
  logic    retire_fire;

  // the stage drains only when the outside takes the op
  assign ws_allowin   = !ws_valid || retire_ready;
  assign retire_valid = ws_valid;
  assign retire_fire  = ws_valid && retire_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      ws_valid <= 1'b0;
    end else if (ws_allowin) begin
      ws_valid <= ms2ws_valid;
    end
    if (ms2ws_valid && ws_allowin) begin
      ws_bus <= ms2ws_bus;
    end
  end

  assign retire.pc     = ws_bus.pc;
  assign retire.gr_we  = ws_bus.gr_we;
  assign retire.dest   = ws_bus.dest;
  assign retire.result = ws_bus.result;

  // register file sees the write at the retire edge
  assign rf_write.we   = retire_fire && ws_bus.gr_we;
  assign rf_write.addr = ws_bus.dest;
  assign rf_write.data = ws_bus.result;

  assign wb_fwd.valid   = ws_valid;
  assign wb_fwd.gr_we   = ws_bus.gr_we;
  assign wb_fwd.is_load = 1'b0;
  assign wb_fwd.dest    = ws_bus.dest;
  assign wb_fwd.value   = ws_bus.result;

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_exe_pipe \
  -Mdir obj_dir -o sim_tb_exe_pipe
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build returned status $status"
  exit "$status"
fi

./obj_dir/sim_tb_exe_pipe
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation returned status $status"
  exit "$status"
fi

exit 0

/* tests/tb_exe_pipe.sv */
`timescale 1ns/1ps

module tb_exe_pipe import isa_pkg::*, pipe_types_pkg::*; ();

  localparam int          CLK_PERIOD = 40;
  localparam int          N_OPS      = 400;
  localparam logic [31:0] SEED       = 32'h7d2e_f1a0;

  logic      clk = 1'b0;
  logic      reset;
  logic      op_valid;
  logic      op_ready;
  issue_op_t op;
  logic      retire_valid;
  logic      retire_ready;
  retire_t   retire;

  // reference model state
  logic [31:0] model_rf [NUM_REGS];
  logic [31:0] model_mem [16];
  logic        mem_written [16];
  retire_t     exp_q [$];
  retire_t     exp_head;
  logic        exp_empty;

  logic [31:0] rng_state;
  logic [31:0] next_pc;
  issue_op_t   cur_op;
  logic        have_op;
  logic [3:0]  stall_left;
  int          n_sent;
  int          n_accepted;

  // handshakes seen at the last rising edge
  logic    acc_seen;
  logic    ret_seen;
  logic    held_wait;
  retire_t held_retire;

  always #(CLK_PERIOD / 2) clk = ~clk;

  exe_pipe_top i_exe_pipe_top (
    .clk, .reset, .op_valid, .op_ready, .op,
    .retire_valid, .retire_ready, .retire
  );

  always @(posedge clk) begin
    acc_seen    <= op_valid && op_ready;
    ret_seen    <= retire_valid && retire_ready;
    held_wait   <= retire_valid && !retire_ready;
    held_retire <= retire;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    fail_run($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] rand_u32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // expected alu result for a one-hot op code
  function automatic logic [31:0] ref_alu(input alu_op_t f, input logic [31:0] a,
                                          input logic [31:0] b);
    int idx;
    idx = 0;
    for (int i = 0; i < ALU_OP_W; i++) begin
      if (f[i]) idx = i;
    end
    case (idx)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'd0, a < b};
      ALU_AND:  return a & b;
      ALU_NOR:  return ~(a | b);
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      default:  return b;
    endcase
  endfunction

  // applies one accepted op to the model and queues its retire
  task automatic apply_op(input issue_op_t o);
    logic [31:0] a;
    logic [31:0] b_reg;
    logic [31:0] res;
    retire_t     e;
    a     = model_rf[o.src1];
    b_reg = model_rf[o.src2];
    res   = ref_alu(o.alu_op, a, o.use_imm ? o.imm : b_reg);
    if (o.mem_we) begin
      model_mem[res[5:2]]   = b_reg;
      mem_written[res[5:2]] = 1'b1;
    end
    if (o.res_from_mem) res = model_mem[res[5:2]];
    if (o.gr_we && o.dest != 5'd0) model_rf[o.dest] = res;
    e.pc     = o.pc;
    e.gr_we  = o.gr_we;
    e.dest   = o.dest;
    e.result = res;
    exp_q.push_back(e);
  endtask

  // registers 0..7 and 16 words keep dependencies dense
  task automatic gen_op(output issue_op_t o);
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] target;
    logic [3:0]  w;
    r  = rand_u32();
    r2 = rand_u32();
    o  = '0;
    o.pc   = next_pc;
    o.src1 = {2'b00, r[2:0]};
    o.src2 = {2'b00, r[5:3]};
    o.dest = {2'b00, r[8:6]};
    w      = r[12:9];
    target = {26'd0, w, r[14:13]};
    next_pc = next_pc + 32'd4;
    if (r[18:15] < 4'd5) begin
      // imm chosen so that src1 plus imm lands on word w
      o.alu_op[ALU_ADD] = 1'b1;
      o.use_imm         = 1'b1;
      o.imm             = target - model_rf[o.src1];
      if (r[18:15] < 4'd3 && mem_written[w]) begin
        o.res_from_mem = 1'b1;
        o.gr_we        = 1'b1;
      end else begin
        o.mem_we = 1'b1;
      end
    end else begin
      o.alu_op[r2[3:0] % 4'd12] = 1'b1;
      o.use_imm = r[19];
      o.gr_we   = (r[22:20] != 3'd0);
      o.imm     = r[23] ? r2 : {27'd0, r2[8:4]};
    end
  endtask

  // books the last handshakes and drives new inputs
  task automatic cycle();
    logic [31:0] r;
    if (ret_seen && exp_q.size() != 0) exp_q.delete(0);
    if (acc_seen) begin
      apply_op(cur_op);
      have_op    = 1'b0;
      n_accepted = n_accepted + 1;
    end
    exp_empty = (exp_q.size() == 0);
    if (!exp_empty) exp_head = exp_q[0];

    r = rand_u32();
    if (!have_op && n_sent < N_OPS && r[2:0] != 3'd0) begin
      gen_op(cur_op);
      have_op = 1'b1;
      n_sent  = n_sent + 1;
    end
    op_valid = have_op;
    op       = cur_op;

    // retire_ready mixes single gaps with longer back-pressure runs
    if (stall_left != 4'd0) begin
      stall_left   = stall_left - 4'd1;
      retire_ready = 1'b0;
    end else if (r[13:10] == 4'd0) begin
      stall_left   = r[7:4];
      retire_ready = 1'b0;
    end else begin
      retire_ready = (r[9:8] != 2'd0);
    end
  endtask

  assert property (@(posedge clk) disable iff (reset)
    (retire_valid && retire_ready) |-> !exp_empty)
    else fail_run("an op retired that was never accepted");
  assert property (@(posedge clk) disable iff (reset)
    (retire_valid && retire_ready) |-> retire.pc == exp_head.pc)
    else value_mismatch("retire.pc", retire.pc, exp_head.pc);
  assert property (@(posedge clk) disable iff (reset)
    (retire_valid && retire_ready) |-> retire.gr_we == exp_head.gr_we)
    else value_mismatch("retire.gr_we", 32'(retire.gr_we), 32'(exp_head.gr_we));
  assert property (@(posedge clk) disable iff (reset)
    (retire_valid && retire_ready) |-> retire.dest == exp_head.dest)
    else value_mismatch("retire.dest", 32'(retire.dest), 32'(exp_head.dest));
  assert property (@(posedge clk) disable iff (reset)
    (retire_valid && retire_ready) |-> retire.result == exp_head.result)
    else value_mismatch("retire.result", retire.result, exp_head.result);

  // a retire that is not taken must stay put
  assert property (@(posedge clk) disable iff (reset)
    held_wait |-> retire_valid)
    else fail_run("retire_valid dropped before the op was accepted");
  assert property (@(posedge clk) disable iff (reset)
    held_wait |-> retire == held_retire)
    else fail_run($sformatf("CHECK FAILED retire got 0x%h expected 0x%h",
                            retire, held_retire));

  initial begin
    repeat (N_OPS * 12 + 100) @(posedge clk);
    fail_run("watchdog expired before all ops retired");
  end

  initial begin
    reset        = 1'b1;
    op_valid     = 1'b0;
    op           = '0;
    retire_ready = 1'b0;
    rng_state    = SEED;
    next_pc      = 32'h0000_1000;
    cur_op       = '0;
    have_op      = 1'b0;
    stall_left   = 4'd0;
    n_sent       = 0;
    n_accepted   = 0;
    exp_head     = '0;
    exp_empty    = 1'b1;
    for (int i = 0; i < NUM_REGS; i++) model_rf[i] = '0;
    for (int i = 0; i < 16; i++) begin
      model_mem[i]   = '0;
      mem_written[i] = 1'b0;
    end

    repeat (2) @(negedge clk);
    assert (retire_valid == 1'b0) else fail_run("retire_valid high during reset");
    assert (op_ready == 1'b1) else fail_run("op_ready low during reset");
    reset = 1'b0;

    cycle();
    while (!(n_accepted == N_OPS && exp_q.size() == 0)) begin
      @(negedge clk);
      cycle();
    end
    // a few idle cycles so a stray retire is caught
    repeat (4) begin
      @(negedge clk);
      cycle();
    end

    $display("Regression passed");
    $finish;
  end

endmodule

/* vlog.f */
hw/isa_pkg.sv
hw/pipe_types_pkg.sv
hw/alu.sv
hw/issue_stage.sv
hw/exe_stage.sv
hw/data_ram.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/exe_pipe_top.sv
tests/tb_exe_pipe.sv
